/* Makefile */
# Verilator simulation of the RV32 execute path

VERILATOR ?= verilator
TOP       ?= exu_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage
  import exu_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      dec_valid,
  input  alu_op_t   dec_op,
  input  reg_addr_t dec_rs1,
  input  reg_addr_t dec_rs2,
  input  reg_addr_t dec_rd,
  input  word_t     dec_imm,
  input  logic      dec_use_imm,
  input  logic      dec_lui,
  input  logic      dec_illegal,
  input  word_t     rdata1,
  input  word_t     rdata2,
  output logic      ex_valid,
  output reg_addr_t ex_rd,
  output word_t     ex_result,
  output logic      ex_zero,
  output logic      ex_illegal
);

  word_t src1;
  word_t src2;
  word_t alu_result;
  logic  alu_zero;
  logic  fwd1;
  logic  fwd2;

  // Result one stage ahead is not in the register file yet
  assign fwd1 = ex_valid && (ex_rd != '0) && (ex_rd == dec_rs1);
  assign fwd2 = ex_valid && (ex_rd != '0) && (ex_rd == dec_rs2);

  always_comb begin
    if (dec_lui) begin
      src1 = '0;
    end else if (fwd1) begin
      src1 = ex_result;
    end else begin
      src1 = rdata1;
    end
  end

  always_comb begin
    if (dec_use_imm) begin
      src2 = dec_imm;
    end else if (fwd2) begin
      src2 = ex_result;
    end else begin
      src2 = rdata2;
    end
  end

  exu u_exu (
    .src1       (src1),
    .src2       (src2),
    .alu_op     (dec_op),
    .alu_result (alu_result),
    .zero       (alu_zero)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_valid   <= 1'b0;
      ex_illegal <= 1'b0;
    end else begin
      ex_valid   <= dec_valid;
      ex_illegal <= dec_valid & dec_illegal;
    end
  end

  // Illegal ops carry zeros downstream
  always_ff @(posedge clk) begin
    if (dec_valid) begin
      ex_rd     <= dec_illegal ? '0 : dec_rd;
      ex_result <= dec_illegal ? '0 : alu_result;
      ex_zero   <= dec_illegal ? 1'b0 : alu_zero;
    end
  end

endmodule

/* design/exu.sv */
`timescale 1ns/1ps
`include "exu_settings.svh"

module exu
  import exu_pkg::*;
(
  input  word_t   src1,
  input  word_t   src2,
  input  alu_op_t alu_op,
  output word_t   alu_result,
  output logic    zero
);

  localparam word_t most_neg = {1'b1, {(`EXU_XLEN-1){1'b0}}};

  logic [4:0]         shamt;
  logic [`EXU_XLEN:0] ules_diff;
  logic               div_zero;
  logic               div_ovf;

  assign shamt     = src2[4:0];
  assign ules_diff = {1'b0, src1} - {1'b0, src2};
  assign div_zero  = (src2 == '0);
  // INT_MIN / -1 overflows
  assign div_ovf   = (src1 == most_neg) && (src2 == '1);

  always_comb begin
    alu_result = '0;
    zero       = 1'b0;
    case (alu_op)
      `EXU_OP_IMM: alu_result = src2;
      `EXU_OP_ADD: begin
        alu_result = src1 + src2;
        zero       = (alu_result == '0);
      end
      `EXU_OP_SUB: begin
        alu_result = src1 - src2;
        zero       = (alu_result == '0);
      end
      `EXU_OP_AND: alu_result = src1 & src2;
      `EXU_OP_XOR: alu_result = src1 ^ src2;
      `EXU_OP_OR:  alu_result = src1 | src2;
      `EXU_OP_SL:  alu_result = src1 << shamt;
      `EXU_OP_SR:  alu_result = src1 >> shamt;
      `EXU_OP_DIV: begin
        if (div_zero) begin
          alu_result = '1;
        end else if (div_ovf) begin
          alu_result = most_neg;
        end else begin
          alu_result = $signed(src1) / $signed(src2);
        end
      end
      `EXU_OP_SSR:  alu_result = $signed(src1) >>> shamt;
      `EXU_OP_SLES: alu_result = {{(`EXU_XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
      // Borrow out means src1 < src2
      `EXU_OP_ULES: alu_result = {{(`EXU_XLEN-1){1'b0}}, ules_diff[`EXU_XLEN]};
      `EXU_OP_REMU: alu_result = div_zero ? src1 : (src1 % src2);
      `EXU_OP_MUL:  alu_result = src1 * src2;
      `EXU_OP_DIVU: alu_result = div_zero ? '1 : (src1 / src2);
      `EXU_OP_REM: begin
        if (div_zero) begin
          alu_result = src1;
        end else if (div_ovf) begin
          alu_result = '0;
        end else begin
          alu_result = $signed(src1) % $signed(src2);
        end
      end
      default: alu_result = '0;
    endcase
  end

endmodule

/* design/exu_core.sv */
`timescale 1ns/1ps

module exu_core
  import exu_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      instr_valid,
  input  instr_t    instr,
  output logic      retire_valid,
  output reg_addr_t retire_rd,
  output word_t     retire_result,
  output logic      retire_zero,
  output logic      retire_illegal
);

  logic      dec_valid;
  alu_op_t   dec_op;
  reg_addr_t dec_rs1;
  reg_addr_t dec_rs2;
  reg_addr_t dec_rd;
  word_t     dec_imm;
  logic      dec_use_imm;
  logic      dec_lui;
  logic      dec_illegal;
  word_t     rdata1;
  word_t     rdata2;
  logic      ex_valid;
  reg_addr_t ex_rd;
  word_t     ex_result;
  logic      ex_zero;
  logic      ex_illegal;
  logic      wen;
  reg_addr_t waddr;
  word_t     wdata;

  idu u_idu (
    .clk, .reset, .instr_valid, .instr,
    .dec_valid, .dec_op, .dec_rs1, .dec_rs2, .dec_rd,
    .dec_imm, .dec_use_imm, .dec_lui, .dec_illegal
  );

  // Read addresses come straight from the decoder registers
  regfile u_regfile (
    .clk, .reset,
    .raddr1 (dec_rs1),
    .raddr2 (dec_rs2),
    .rdata1, .rdata2,
    .wen, .waddr, .wdata
  );

  ex_stage u_ex_stage (
    .clk, .reset,
    .dec_valid, .dec_op, .dec_rs1, .dec_rs2, .dec_rd,
    .dec_imm, .dec_use_imm, .dec_lui, .dec_illegal,
    .rdata1, .rdata2,
    .ex_valid, .ex_rd, .ex_result, .ex_zero, .ex_illegal
  );

  wbu u_wbu (
    .clk, .reset,
    .ex_valid, .ex_rd, .ex_result, .ex_zero, .ex_illegal,
    .wen, .waddr, .wdata,
    .retire_valid, .retire_rd, .retire_result, .retire_zero, .retire_illegal
  );

endmodule

/* design/exu_pkg.sv */
`include "exu_settings.svh"

package exu_pkg;

  // One data word
  typedef logic [`EXU_XLEN-1:0] word_t;

  // One instruction word
  typedef logic [`EXU_ILEN-1:0] instr_t;

  // Register index
  typedef logic [`EXU_REG_AW-1:0] reg_addr_t;

  // ALU operation code
  typedef logic [`EXU_ALU_OPW-1:0] alu_op_t;

endpackage

/* design/exu_settings.svh */
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// Datapath sizes
`define EXU_XLEN     32
`define EXU_ILEN     32
`define EXU_NREGS    32
`define EXU_REG_AW   5
`define EXU_ALU_OPW  4

// ALU operation codes
`define EXU_OP_IMM   4'd0
`define EXU_OP_ADD   4'd1
`define EXU_OP_SUB   4'd2
`define EXU_OP_AND   4'd3
`define EXU_OP_XOR   4'd4
`define EXU_OP_OR    4'd5
`define EXU_OP_SL    4'd6
`define EXU_OP_SR    4'd7
`define EXU_OP_DIV   4'd8
`define EXU_OP_SSR   4'd9
`define EXU_OP_SLES  4'd10
`define EXU_OP_ULES  4'd11
`define EXU_OP_REMU  4'd12
`define EXU_OP_MUL   4'd13
`define EXU_OP_DIVU  4'd14
`define EXU_OP_REM   4'd15

// RV32 major opcodes handled here
`define EXU_OPC_OP      7'b0110011
`define EXU_OPC_OP_IMM  7'b0010011
`define EXU_OPC_LUI     7'b0110111

// funct7 groups
`define EXU_F7_BASE    7'b0000000
`define EXU_F7_ALT     7'b0100000
`define EXU_F7_MULDIV  7'b0000001

`endif

/* design/idu.sv */
`timescale 1ns/1ps
`include "exu_settings.svh"

module idu
  import exu_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      instr_valid,
  input  instr_t    instr,
  output logic      dec_valid,
  output alu_op_t   dec_op,
  output reg_addr_t dec_rs1,
  output reg_addr_t dec_rs2,
  output reg_addr_t dec_rd,
  output word_t     dec_imm,
  output logic      dec_use_imm,
  output logic      dec_lui,
  output logic      dec_illegal
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  alu_op_t    op_c;
  word_t      imm_c;
  logic       use_imm_c;
  logic       lui_c;
  logic       illegal_c;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  always_comb begin
    op_c      = `EXU_OP_ADD;
    imm_c     = {{20{instr[31]}}, instr[31:20]};
    use_imm_c = 1'b0;
    lui_c     = 1'b0;
    illegal_c = 1'b0;
    case (opcode)
      `EXU_OPC_OP: begin
        case (funct7)
          `EXU_F7_BASE: begin
            case (funct3)
              3'b000: op_c = `EXU_OP_ADD;
              3'b001: op_c = `EXU_OP_SL;
              3'b010: op_c = `EXU_OP_SLES;
              3'b011: op_c = `EXU_OP_ULES;
              3'b100: op_c = `EXU_OP_XOR;
              3'b101: op_c = `EXU_OP_SR;
              3'b110: op_c = `EXU_OP_OR;
              default: op_c = `EXU_OP_AND;
            endcase
          end
          `EXU_F7_ALT: begin
            case (funct3)
              3'b000: op_c = `EXU_OP_SUB;
              3'b101: op_c = `EXU_OP_SSR;
              default: illegal_c = 1'b1;
            endcase
          end
          `EXU_F7_MULDIV: begin
            // MULH variants are not supported
            case (funct3)
              3'b000: op_c = `EXU_OP_MUL;
              3'b100: op_c = `EXU_OP_DIV;
              3'b101: op_c = `EXU_OP_DIVU;
              3'b110: op_c = `EXU_OP_REM;
              3'b111: op_c = `EXU_OP_REMU;
              default: illegal_c = 1'b1;
            endcase
          end
          default: illegal_c = 1'b1;
        endcase
      end
      `EXU_OPC_OP_IMM: begin
        use_imm_c = 1'b1;
        case (funct3)
          3'b000: op_c = `EXU_OP_ADD;
          3'b010: op_c = `EXU_OP_SLES;
          3'b011: op_c = `EXU_OP_ULES;
          3'b100: op_c = `EXU_OP_XOR;
          3'b110: op_c = `EXU_OP_OR;
          3'b111: op_c = `EXU_OP_AND;
          3'b001: begin
            op_c      = `EXU_OP_SL;
            illegal_c = (funct7 != `EXU_F7_BASE);
          end
          default: begin
            // SRLI or SRAI with shamt in the low immediate bits
            if (funct7 == `EXU_F7_BASE) begin
              op_c = `EXU_OP_SR;
            end else if (funct7 == `EXU_F7_ALT) begin
              op_c = `EXU_OP_SSR;
            end else begin
              illegal_c = 1'b1;
            end
          end
        endcase
      end
      `EXU_OPC_LUI: begin
        op_c      = `EXU_OP_IMM;
        imm_c     = {instr[31:12], 12'b0};
        use_imm_c = 1'b1;
        lui_c     = 1'b1;
      end
      default: illegal_c = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dec_valid   <= 1'b0;
      dec_illegal <= 1'b0;
    end else begin
      dec_valid   <= instr_valid;
      dec_illegal <= instr_valid & illegal_c;
    end
  end

  always_ff @(posedge clk) begin
    if (instr_valid) begin
      dec_op      <= op_c;
      dec_rs1     <= instr[19:15];
      dec_rs2     <= instr[24:20];
      dec_rd      <= instr[11:7];
      dec_imm     <= imm_c;
      dec_use_imm <= use_imm_c;
      dec_lui     <= lui_c;
    end
  end

  a_illegal_needs_valid: assert property (
    @(posedge clk) disable iff (reset) dec_illegal |-> dec_valid
  );

endmodule

/* design/regfile.sv */
`timescale 1ns/1ps
`include "exu_settings.svh"

module regfile
  import exu_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  reg_addr_t raddr1,
  input  reg_addr_t raddr2,
  output word_t     rdata1,
  output word_t     rdata2,
  input  logic      wen,
  input  reg_addr_t waddr,
  input  word_t     wdata
);

  word_t regs [`EXU_NREGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `EXU_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 first, then the pending write, then the array
  always_comb begin
    if (raddr1 == '0) begin
      rdata1 = '0;
    end else if (wen && (waddr == raddr1)) begin
      rdata1 = wdata;
    end else begin
      rdata1 = regs[raddr1];
    end
    if (raddr2 == '0) begin
      rdata2 = '0;
    end else if (wen && (waddr == raddr2)) begin
      rdata2 = wdata;
    end else begin
      rdata2 = regs[raddr2];
    end
  end

  a_x0_reads_zero: assert property (
    @(posedge clk) disable iff (reset)
      (regs[0] == '0) && ((raddr1 != '0) || (rdata1 == '0)) &&
      ((raddr2 != '0) || (rdata2 == '0))
  );

endmodule

/* design/wbu.sv */
`timescale 1ns/1ps

module wbu
  import exu_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      ex_valid,
  input  reg_addr_t ex_rd,
  input  word_t     ex_result,
  input  logic      ex_zero,
  input  logic      ex_illegal,
  output logic      wen,
  output reg_addr_t waddr,
  output word_t     wdata,
  output logic      retire_valid,
  output reg_addr_t retire_rd,
  output word_t     retire_result,
  output logic      retire_zero,
  output logic      retire_illegal
);

  always_ff @(posedge clk) begin
    if (reset) begin
      retire_valid   <= 1'b0;
      retire_illegal <= 1'b0;
      wen            <= 1'b0;
    end else begin
      retire_valid   <= ex_valid;
      retire_illegal <= ex_valid & ex_illegal;
      // No write for x0 or illegal ops
      wen            <= ex_valid & ~ex_illegal & (ex_rd != '0);
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid) begin
      retire_rd     <= ex_rd;
      retire_result <= ex_result;
      retire_zero   <= ex_zero;
    end
  end

  assign waddr = retire_rd;
  assign wdata = retire_result;

  a_wen_legal_retire: assert property (
    @(posedge clk) disable iff (reset) wen |-> (retire_valid && !retire_illegal)
  );

endmodule

/* sim.f */
+incdir+design
+incdir+tests
design/exu_pkg.sv
design/idu.sv
design/regfile.sv
design/exu.sv
design/ex_stage.sv
design/wbu.sv
design/exu_core.sv
tests/exu_tb.sv

/* tests/exu_model.svh */
`ifndef EXU_MODEL_SVH
`define EXU_MODEL_SVH

// Galois LFSR on x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int k = 0; k < n; k++) begin
    lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
    v = {v[30:0], lfsr_state[0]};
  end
  return v;
endfunction

// Small pool x0..x7 so that operands often depend on recent results
function automatic logic [4:0] rand_reg();
  logic [31:0] v;
  v = rand_bits(3);
  return {2'b00, v[2:0]};
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd);
  return {imm, rs1, f3, rd, 7'b0010011};
endfunction

function automatic logic [31:0] enc_lui(input logic [19:0] imm, input logic [4:0] rd);
  return {imm, rd, 7'b0110111};
endfunction

// LW lies outside the supported groups
function automatic logic [31:0] enc_load(input logic [4:0] rs1, input logic [4:0] rd);
  return {12'h000, rs1, 3'b010, rd, 7'b0000011};
endfunction

// Reference behavior of one instruction including the model register update
function automatic void model_exec(input logic [31:0] ins, output logic ill,
                                   output logic [4:0] rd, output logic [31:0] res,
                                   output logic z);
  logic [6:0]  opc;
  logic [6:0]  f7;
  logic [2:0]  f3;
  logic [31:0] a;
  logic [31:0] b;
  logic [4:0]  sh;
  logic        ovf;
  opc = ins[6:0];
  f3  = ins[14:12];
  f7  = ins[31:25];
  rd  = ins[11:7];
  a   = model_regs[ins[19:15]];
  b   = model_regs[ins[24:20]];
  ill = 1'b0;
  res = '0;
  z   = 1'b0;
  if (opc == 7'b0010011) begin
    b = {{20{ins[31]}}, ins[31:20]};
    // funct7 only matters for the shift forms
    if (f3 != 3'd1 && f3 != 3'd5) begin
      f7 = 7'h00;
    end
  end
  sh  = b[4:0];
  ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
  if (opc == 7'b0110111) begin
    res = {ins[31:12], 12'h000};
  end else if (opc == 7'b0110011 && f7 == 7'h01) begin
    case (f3)
      3'd0: res = a * b;
      3'd4: begin
        if (b == 0) begin
          res = 32'hffff_ffff;
        end else if (ovf) begin
          res = 32'h8000_0000;
        end else begin
          res = $signed(a) / $signed(b);
        end
      end
      3'd5: res = (b == 0) ? 32'hffff_ffff : a / b;
      3'd6: begin
        if (b == 0) begin
          res = a;
        end else if (ovf) begin
          res = 32'h0;
        end else begin
          res = $signed(a) % $signed(b);
        end
      end
      3'd7: res = (b == 0) ? a : a % b;
      default: ill = 1'b1;
    endcase
  end else if (opc == 7'b0110011 || opc == 7'b0010011) begin
    if (f7 != 7'h00 && f7 != 7'h20) begin
      ill = 1'b1;
    end else if (f7 == 7'h20 && f3 != 3'd0 && f3 != 3'd5) begin
      ill = 1'b1;
    end else begin
      case (f3)
        3'd0: begin
          res = (f7 == 7'h20) ? a - b : a + b;
          z   = (res == 32'h0);
        end
        3'd1: res = a << sh;
        3'd2: res = {31'b0, ($signed(a) < $signed(b))};
        3'd3: res = {31'b0, (a < b)};
        3'd4: res = a ^ b;
        3'd5: begin
          if (f7 == 7'h20) begin
            res = $signed(a) >>> sh;
          end else begin
            res = a >> sh;
          end
        end
        3'd6: res = a | b;
        default: res = a & b;
      endcase
    end
  end else begin
    ill = 1'b1;
  end
  if (ill) begin
    rd  = '0;
    res = '0;
    z   = 1'b0;
  end else if (rd != 5'd0) begin
    model_regs[rd] = res;
  end
endfunction

`endif

/* tests/exu_tb.sv */
`timescale 1ns/1ps

module exu_tb;

  localparam int n_random    = 600;
  localparam int drain_limit = 20;

  typedef struct packed {
    int          cyc;
    logic [4:0]  rd;
    logic [31:0] res;
    logic        z;
    logic        ill;
  } expect_t;

  logic        clk = 1'b0;
  logic        reset = 1'b1;
  logic        instr_valid = 1'b0;
  logic [31:0] instr = '0;
  logic        retire_valid;
  logic [4:0]  retire_rd;
  logic [31:0] retire_result;
  logic        retire_zero;
  logic        retire_illegal;

  logic [15:0] lfsr_state;
  logic [31:0] model_regs [32];
  expect_t     exp_q [$];
  int          cycle = 0;
  int          errors;
  int          checks;

  `include "exu_model.svh"

  exu_core u_dut (
    .clk, .reset, .instr_valid, .instr,
    .retire_valid, .retire_rd, .retire_result, .retire_zero, .retire_illegal
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic check_field(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error at %0t: %s expected 0x%08h, got 0x%08h", $time, name, exp, got);
    end
  endtask

  // Drive one instruction for one cycle and record its expectation
  task automatic issue(input logic [31:0] ins);
    expect_t     e;
    logic        ill;
    logic [4:0]  rd;
    logic [31:0] res;
    logic        z;
    instr_valid = 1'b1;
    instr       = ins;
    model_exec(ins, ill, rd, res, z);
    e.cyc = cycle;
    e.rd  = rd;
    e.res = res;
    e.z   = z;
    e.ill = ill;
    exp_q.push_back(e);
    @(posedge clk);
    #1;
    instr_valid = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    instr_valid = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < drain_limit) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("Timed out after %0d cycles with %0d retirements outstanding",
               waited, exp_q.size());
    end
  endtask

  function automatic logic [31:0] random_instr();
    logic [31:0] cls;
    logic [31:0] sel;
    logic [31:0] v;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    cls = rand_bits(4);
    rd  = rand_reg();
    rs1 = rand_reg();
    rs2 = rand_reg();
    v   = rand_bits(3);
    f3  = v[2:0];
    sel = rand_bits(2);
    if (cls < 5) begin
      f7 = ((sel[0] == 1'b1) && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
      return enc_r(f7, rs2, rs1, f3, rd);
    end else if (cls < 9) begin
      if (f3 >= 3'd1 && f3 <= 3'd3) begin
        f3 = 3'd0;
      end
      return enc_r(7'h01, rs2, rs1, f3, rd);
    end else if (cls < 13) begin
      v   = rand_bits(12);
      imm = v[11:0];
      if (f3 == 3'd1) begin
        imm[11:5] = 7'h00;
      end else if (f3 == 3'd5) begin
        imm[11:5] = (sel[0] == 1'b1) ? 7'h20 : 7'h00;
      end
      return enc_i(imm, rs1, f3, rd);
    end else if (cls < 15) begin
      v = rand_bits(20);
      return enc_lui(v[19:0], rd);
    end
    // Illegal encodings
    case (sel[1:0])
      2'd0: return enc_load(rs1, rd);
      2'd1: return enc_r(7'h01, rs2, rs1, 3'd1, rd);
      2'd2: return enc_r(7'h20, rs2, rs1, 3'd2, rd);
      default: return enc_i({7'h20, 5'd3}, rs1, 3'd1, rd);
    endcase
  endfunction

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    expect_t e;
    if (reset) begin
      assert (retire_valid === 1'b0) else begin
        errors++;
        $display("** Error at %0t: retire_valid expected 0, got %0b", $time, retire_valid);
      end
    end else if (retire_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Retirement at %0t with no instruction outstanding", $time);
      end else begin
        e = exp_q.pop_front();
        check_field("retire cycle", e.cyc + 3, cycle);
        check_field("retire_rd", {27'b0, e.rd}, {27'b0, retire_rd});
        check_field("retire_result", e.res, retire_result);
        check_field("retire_zero", {31'b0, e.z}, {31'b0, retire_zero});
        check_field("retire_illegal", {31'b0, e.ill}, {31'b0, retire_illegal});
      end
    end else if (exp_q.size() != 0 && cycle > exp_q[0].cyc + 3) begin
      errors++;
      $display("Instruction issued in cycle %0d never retired", exp_q[0].cyc);
      void'(exp_q.pop_front());
    end
  end

  initial begin
    logic [31:0] v;
    lfsr_state = 16'd1476;
    errors     = 0;
    checks     = 0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    idle_cycles(5);

    // Every register reads zero after reset
    for (int i = 0; i < 32; i++) begin
      issue(enc_r(7'h00, 5'd0, i[4:0], 3'd0, 5'd0));
    end

    // Divide corner cases with x3 still zero
    issue(enc_lui(20'h80000, 5'd1));
    issue(enc_i(12'hfff, 5'd0, 3'd0, 5'd2));
    issue(enc_r(7'h01, 5'd3, 5'd1, 3'd4, 5'd4));
    issue(enc_r(7'h01, 5'd3, 5'd1, 3'd5, 5'd5));
    issue(enc_r(7'h01, 5'd3, 5'd1, 3'd6, 5'd6));
    issue(enc_r(7'h01, 5'd3, 5'd1, 3'd7, 5'd7));
    issue(enc_r(7'h01, 5'd2, 5'd1, 3'd4, 5'd4));
    issue(enc_r(7'h01, 5'd2, 5'd1, 3'd6, 5'd5));

    // Shift amounts of 31
    issue(enc_r(7'h00, 5'd2, 5'd2, 3'd1, 5'd6));
    issue(enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd7));
    issue(enc_i(12'h01f, 5'd1, 3'd5, 5'd6));
    issue(enc_i(12'h41f, 5'd1, 3'd5, 5'd7));

    // Dependent chain with no gaps
    issue(enc_i(12'h005, 5'd0, 3'd0, 5'd5));
    issue(enc_r(7'h00, 5'd5, 5'd5, 3'd0, 5'd5));
    issue(enc_r(7'h00, 5'd5, 5'd5, 3'd0, 5'd5));
    issue(enc_r(7'h20, 5'd5, 5'd5, 3'd0, 5'd6));
    issue(enc_r(7'h00, 5'd2, 5'd6, 3'd0, 5'd6));

    // x0 and illegal ops leave the registers alone
    issue(enc_i(12'h007, 5'd0, 3'd0, 5'd0));
    issue(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd4));
    issue(enc_load(5'd2, 5'd1));
    issue(enc_r(7'h01, 5'd2, 5'd2, 3'd1, 5'd1));
    issue(enc_r(7'h00, 5'd0, 5'd1, 3'd0, 5'd7));

    for (int i = 0; i < n_random; i++) begin
      v = rand_bits(2);
      if (v != 0) begin
        issue(random_instr());
      end else begin
        idle_cycles(1);
      end
    end

    // Final sweep of the register pool
    for (int i = 0; i < 8; i++) begin
      issue(enc_r(7'h00, 5'd0, i[4:0], 3'd0, 5'd0));
    end
    idle_cycles(1);
    wait_drain();

    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
